/* source/pid_defines.svh */
`ifndef PID_DEFINES_SVH
`define PID_DEFINES_SVH

// Channel count and channel index width
`define PID_N_CHAN      8
`define PID_W_CHAN      3

// Datapath widths
`define PID_W_DATA_IN   16
`define PID_W_COEF      16
`define PID_W_K         18
`define PID_W_DATA_OUT  32

// Register write port
`define PID_W_WR_ADDR   4
`define PID_W_WR_DATA   32

// Cycles from dv_in to dv_out
`define PID_LATENCY     6

`endif

/* source/pid_pkg.sv */
`include "pid_defines.svh"
`default_nettype none

package pid_pkg;

    // Register map of the write port
    typedef enum logic [`PID_W_WR_ADDR-1:0] {
        REG_CLEAR    = 4'd0,
        REG_SETPOINT = 4'd1,
        REG_P_COEF   = 4'd2,
        REG_I_COEF   = 4'd3,
        REG_D_COEF   = 4'd4
    } pid_reg_e;

    // Input sample and setpoint
    typedef logic signed [`PID_W_DATA_IN-1:0] sample_t;

    // Raw P, I and D gains
    typedef logic signed [`PID_W_COEF-1:0] coef_t;

    // Folded z-domain gains k1..k3, two bits of headroom
    typedef logic signed [`PID_W_K-1:0] kcoef_t;

    // Saturated controller output
    typedef logic signed [`PID_W_DATA_OUT-1:0] out_t;

endpackage

`default_nettype wire

/* source/pid_cfg_if.sv */
`include "pid_defines.svh"
`default_nettype none

interface pid_cfg_if;

    // Channel of the sample entering the pipeline
    logic [`PID_W_CHAN-1:0] rd_chan;

    // Config of rd_chan, combinational lookup
    pid_pkg::sample_t setpoint;
    pid_pkg::kcoef_t  k1;
    pid_pkg::kcoef_t  k2;
    pid_pkg::kcoef_t  k3;

    // Clear bits of all channels at once
    logic [`PID_N_CHAN-1:0] clr_mask;

    // Register bank side
    modport regs (
        input  rd_chan,
        output setpoint, k1, k2, k3, clr_mask
    );

    // Pipeline side
    modport pipe (
        output rd_chan,
        input  setpoint, k1, k2, k3, clr_mask
    );

endinterface

`default_nettype wire

/* source/pid_cfg_regs.sv */
`include "pid_defines.svh"
`default_nettype none

module pid_cfg_regs (
    input  logic                       sys_clk_in,
    input  logic                       arst_n,
    input  logic                       wr_en,
    input  logic [`PID_W_WR_ADDR-1:0]  wr_addr,
    input  logic [`PID_W_CHAN-1:0]     wr_chan,
    input  logic [`PID_W_WR_DATA-1:0]  wr_data,
    pid_cfg_if.regs                    cfg
);

    // Per-channel config
    logic [`PID_N_CHAN-1:0] clr_q;
    pid_pkg::sample_t setpoint_mem [`PID_N_CHAN];
    pid_pkg::coef_t   p_mem        [`PID_N_CHAN];
    pid_pkg::coef_t   i_mem        [`PID_N_CHAN];
    pid_pkg::coef_t   d_mem        [`PID_N_CHAN];
    pid_pkg::kcoef_t  k1_mem       [`PID_N_CHAN];
    pid_pkg::kcoef_t  k2_mem       [`PID_N_CHAN];
    pid_pkg::kcoef_t  k3_mem       [`PID_N_CHAN];

    pid_pkg::pid_reg_e wr_reg;
    pid_pkg::coef_t    wr_coef;
    pid_pkg::coef_t    p_nxt;
    pid_pkg::coef_t    i_nxt;
    pid_pkg::coef_t    d_nxt;
    pid_pkg::kcoef_t   k1_nxt;
    pid_pkg::kcoef_t   k2_nxt;
    pid_pkg::kcoef_t   k3_nxt;
    logic              coef_wr;

    assign wr_reg  = pid_pkg::pid_reg_e'(wr_addr);
    assign wr_coef = pid_pkg::coef_t'(wr_data[`PID_W_COEF-1:0]);

    //----------------------------------------------------------------------
    // Coefficient folding
    //----------------------------------------------------------------------
    // Gains of wr_chan as they stand after this write
    always_comb begin
        p_nxt   = p_mem[wr_chan];
        i_nxt   = i_mem[wr_chan];
        d_nxt   = d_mem[wr_chan];
        coef_wr = 1'b0;
        case (wr_reg)
            pid_pkg::REG_P_COEF: begin
                p_nxt   = wr_coef;
                coef_wr = 1'b1;
            end
            pid_pkg::REG_I_COEF: begin
                i_nxt   = wr_coef;
                coef_wr = 1'b1;
            end
            pid_pkg::REG_D_COEF: begin
                d_nxt   = wr_coef;
                coef_wr = 1'b1;
            end
            default: ;
        endcase
    end

    // k1 = p+i+d, k2 = -p-2d, k3 = d
    assign k1_nxt = pid_pkg::kcoef_t'(p_nxt) + pid_pkg::kcoef_t'(i_nxt)
                  + pid_pkg::kcoef_t'(d_nxt);
    assign k2_nxt = -pid_pkg::kcoef_t'(p_nxt) - (pid_pkg::kcoef_t'(d_nxt) <<< 1);
    assign k3_nxt = pid_pkg::kcoef_t'(d_nxt);

    //----------------------------------------------------------------------
    // Write decode
    //----------------------------------------------------------------------
    always_ff @(posedge sys_clk_in or negedge arst_n) begin
        if (!arst_n) begin
            clr_q <= '0;
            for (int c = 0; c < `PID_N_CHAN; c++) begin
                setpoint_mem[c] <= '0;
                p_mem[c]        <= '0;
                i_mem[c]        <= '0;
                d_mem[c]        <= '0;
                k1_mem[c]       <= '0;
                k2_mem[c]       <= '0;
                k3_mem[c]       <= '0;
            end
        end else if (wr_en) begin
            case (wr_reg)
                pid_pkg::REG_CLEAR:    clr_q[wr_chan] <= wr_data[0];
                pid_pkg::REG_SETPOINT: setpoint_mem[wr_chan] <= wr_data[`PID_W_DATA_IN-1:0];
                pid_pkg::REG_P_COEF:   p_mem[wr_chan] <= wr_coef;
                pid_pkg::REG_I_COEF:   i_mem[wr_chan] <= wr_coef;
                pid_pkg::REG_D_COEF:   d_mem[wr_chan] <= wr_coef;
                // Unmapped addresses fall through
                default: ;
            endcase
            // Folded gains follow on the same edge
            if (coef_wr) begin
                k1_mem[wr_chan] <= k1_nxt;
                k2_mem[wr_chan] <= k2_nxt;
                k3_mem[wr_chan] <= k3_nxt;
            end
        end
    end

    // Lookup for the sample entering stage 1
    assign cfg.setpoint = setpoint_mem[cfg.rd_chan];
    assign cfg.k1       = k1_mem[cfg.rd_chan];
    assign cfg.k2       = k2_mem[cfg.rd_chan];
    assign cfg.k3       = k3_mem[cfg.rd_chan];
    assign cfg.clr_mask = clr_q;

endmodule

`default_nettype wire

/* source/pid_pipeline.sv */
`include "pid_defines.svh"
`default_nettype none

// PID_LATENCY stages: fetch, error, products, delta, add, saturate
module pid_pipeline (
    input  logic                    sys_clk_in,
    input  logic                    arst_n,
    input  logic                    dv_in,
    input  logic [`PID_W_CHAN-1:0]  chan_in,
    input  pid_pkg::sample_t        data_in,
    pid_cfg_if.pipe                 cfg,
    output logic                    dv_out,
    output logic [`PID_W_CHAN-1:0]  chan_out,
    output pid_pkg::out_t           data_out
);

    // Error keeps one extra bit so setpoint - x never wraps
    localparam int W_ERR   = `PID_W_DATA_IN + 1;
    localparam int W_PROD  = `PID_W_K + W_ERR;
    localparam int W_DELTA = W_PROD + 2;
    localparam int W_INT   = ((W_DELTA > `PID_W_DATA_OUT) ? W_DELTA : `PID_W_DATA_OUT) + 1;

    localparam pid_pkg::out_t OUT_MAX = {1'b0, {(`PID_W_DATA_OUT-1){1'b1}}};
    localparam pid_pkg::out_t OUT_MIN = {1'b1, {(`PID_W_DATA_OUT-1){1'b0}}};

    // Channel history
    logic signed [W_ERR-1:0] e1_mem [`PID_N_CHAN];
    logic signed [W_ERR-1:0] e2_mem [`PID_N_CHAN];
    pid_pkg::out_t           y_prev_mem [`PID_N_CHAN];

    // Valid and channel per stage
    logic [6:1]             dv_q;
    logic [`PID_W_CHAN-1:0] chan_q [6:1];

    // Stage payload
    pid_pkg::sample_t          din_p1;
    pid_pkg::sample_t          setpoint_p1;
    pid_pkg::kcoef_t           k1_p1;
    pid_pkg::kcoef_t           k2_p1;
    pid_pkg::kcoef_t           k3_p1;
    logic signed [W_ERR-1:0]   err_p2;
    logic signed [W_ERR-1:0]   e1_p2;
    logic signed [W_ERR-1:0]   e2_p2;
    pid_pkg::kcoef_t           k1_p2;
    pid_pkg::kcoef_t           k2_p2;
    pid_pkg::kcoef_t           k3_p2;
    logic signed [W_PROD-1:0]  prod0_p3;
    logic signed [W_PROD-1:0]  prod1_p3;
    logic signed [W_PROD-1:0]  prod2_p3;
    logic signed [W_DELTA-1:0] delta_p4;
    pid_pkg::out_t             y_prev_p4;
    logic signed [W_INT-1:0]   sum_p5;
    pid_pkg::out_t             y_p6;
    pid_pkg::out_t             y_sat;

    // Config fetch for the incoming sample
    assign cfg.rd_chan = chan_in;

    //----------------------------------------------------------------------
    // Valid and channel shift
    //----------------------------------------------------------------------
    // Every stage drops a sample whose channel is under clear
    always_ff @(posedge sys_clk_in or negedge arst_n) begin
        if (!arst_n) begin
            dv_q <= '0;
            for (int s = 1; s <= 6; s++) begin
                chan_q[s] <= '0;
            end
        end else begin
            dv_q[1]   <= dv_in & ~cfg.clr_mask[chan_in];
            chan_q[1] <= chan_in;
            for (int s = 2; s <= 6; s++) begin
                dv_q[s]   <= dv_q[s-1] & ~cfg.clr_mask[chan_q[s-1]];
                chan_q[s] <= chan_q[s-1];
            end
        end
    end

    //----------------------------------------------------------------------
    // Arithmetic stages
    //----------------------------------------------------------------------
    always_ff @(posedge sys_clk_in) begin
        // Stage 1
        din_p1      <= data_in;
        setpoint_p1 <= cfg.setpoint;
        k1_p1       <= cfg.k1;
        k2_p1       <= cfg.k2;
        k3_p1       <= cfg.k3;
        // Stage 2, error and its history
        err_p2 <= W_ERR'(setpoint_p1) - W_ERR'(din_p1);
        e1_p2  <= e1_mem[chan_q[1]];
        e2_p2  <= e2_mem[chan_q[1]];
        k1_p2  <= k1_p1;
        k2_p2  <= k2_p1;
        k3_p2  <= k3_p1;
        // Stage 3
        prod0_p3 <= k1_p2 * err_p2;
        prod1_p3 <= k2_p2 * e1_p2;
        prod2_p3 <= k3_p2 * e2_p2;
        // Stage 4, delta and previous output
        delta_p4  <= W_DELTA'(prod0_p3) + W_DELTA'(prod1_p3) + W_DELTA'(prod2_p3);
        y_prev_p4 <= y_prev_mem[chan_q[3]];
        // Stage 5
        sum_p5 <= W_INT'(y_prev_p4) + W_INT'(delta_p4);
        // Stage 6
        y_p6 <= y_sat;
    end

    // Clamp to the output range
    always_comb begin
        if (sum_p5 > W_INT'(OUT_MAX)) begin
            y_sat = OUT_MAX;
        end else if (sum_p5 < W_INT'(OUT_MIN)) begin
            y_sat = OUT_MIN;
        end else begin
            y_sat = pid_pkg::out_t'(sum_p5);
        end
    end

    //----------------------------------------------------------------------
    // History write-back
    //----------------------------------------------------------------------
    always_ff @(posedge sys_clk_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int c = 0; c < `PID_N_CHAN; c++) begin
                e1_mem[c]     <= '0;
                e2_mem[c]     <= '0;
                y_prev_mem[c] <= '0;
            end
        end else begin
            // Error history at the end of stage 2
            if (dv_q[2]) begin
                e1_mem[chan_q[2]] <= err_p2;
                e2_mem[chan_q[2]] <= e1_p2;
            end
            // Output history at the end of stage 5
            if (dv_q[5]) begin
                y_prev_mem[chan_q[5]] <= y_sat;
            end
            // Cleared channels win over any write-back above
            for (int c = 0; c < `PID_N_CHAN; c++) begin
                if (cfg.clr_mask[c]) begin
                    e1_mem[c]     <= '0;
                    e2_mem[c]     <= '0;
                    y_prev_mem[c] <= '0;
                end
            end
        end
    end

    assign dv_out   = dv_q[6];
    assign chan_out = chan_q[6];
    assign data_out = y_p6;

endmodule

`default_nettype wire

/* source/pid_top.sv */
`include "pid_defines.svh"
`default_nettype none

module pid_top (
    input  logic                        sys_clk_in,
    input  logic                        arst_n,
    // Register write port
    input  logic                        wr_en,
    input  logic [`PID_W_WR_ADDR-1:0]   wr_addr,
    input  logic [`PID_W_CHAN-1:0]      wr_chan,
    input  logic [`PID_W_WR_DATA-1:0]   wr_data,
    // Sample stream in
    input  logic                        dv_in,
    input  logic [`PID_W_CHAN-1:0]      chan_in,
    input  logic [`PID_W_DATA_IN-1:0]   data_in,
    // Controller output
    output logic                        dv_out,
    output logic [`PID_W_CHAN-1:0]      chan_out,
    output logic [`PID_W_DATA_OUT-1:0]  data_out
);

    // Config lookup between bank and pipeline
    pid_cfg_if u_cfg_if ();

    pid_cfg_regs u_cfg_regs (
        .sys_clk_in (sys_clk_in),
        .arst_n     (arst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_chan    (wr_chan),
        .wr_data    (wr_data),
        .cfg        (u_cfg_if.regs)
    );

    pid_pipeline u_pipeline (
        .sys_clk_in (sys_clk_in),
        .arst_n     (arst_n),
        .dv_in      (dv_in),
        .chan_in    (chan_in),
        .data_in    (data_in),
        .cfg        (u_cfg_if.pipe),
        .dv_out     (dv_out),
        .chan_out   (chan_out),
        .data_out   (data_out)
    );

endmodule

`default_nettype wire

/* test/pid_chk.sv */
`include "pid_defines.svh"
`default_nettype none

module pid_chk (
    input  logic                        sys_clk_in,
    input  logic                        arst_n,
    input  logic                        dv_in,
    input  logic [`PID_W_CHAN-1:0]      chan_in,
    input  logic                        dv_out,
    input  logic [`PID_W_CHAN-1:0]      chan_out,
    input  logic [`PID_W_DATA_OUT-1:0]  data_out
);
    timeunit 1ns;
    timeprecision 1ps;

    // Read by the testbench for its closing verdict
    int assert_fails = 0;

    // Output strobe stays low under reset
    a_quiet_in_reset: assert property (@(posedge sys_clk_in) !arst_n |-> !dv_out)
        else begin
            assert_fails++;
            $error("dv_out high while arst_n is low");
        end

    // Every output traces back to a sample PID_LATENCY cycles earlier
    a_latency: assert property (@(posedge sys_clk_in) disable iff (!arst_n)
        dv_out |-> ($past(dv_in, `PID_LATENCY) && ($past(chan_in, `PID_LATENCY) == chan_out)))
        else begin
            assert_fails++;
            $error("dv_out without a matching dv_in %0d cycles earlier", `PID_LATENCY);
        end

    // No X or Z on a valid output
    a_known_data: assert property (@(posedge sys_clk_in) dv_out |-> !$isunknown(data_out))
        else begin
            assert_fails++;
            $error("data_out unknown while dv_out is high");
        end

endmodule

`default_nettype wire

/* test/pid_monitor.sv */
`include "pid_defines.svh"
`default_nettype none

module pid_monitor (
    input  logic                        sys_clk_in,
    input  logic                        dv_out,
    input  logic [`PID_W_CHAN-1:0]      chan_out,
    input  logic [`PID_W_DATA_OUT-1:0]  data_out
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam longint OUT_MAX = (longint'(1) <<< (`PID_W_DATA_OUT - 1)) - 1;
    localparam longint OUT_MIN = -(longint'(1) <<< (`PID_W_DATA_OUT - 1));

    // Model config, raw gains as written
    longint setpoint_m [`PID_N_CHAN] = '{default: 0};
    longint p_m        [`PID_N_CHAN] = '{default: 0};
    longint i_m        [`PID_N_CHAN] = '{default: 0};
    longint d_m        [`PID_N_CHAN] = '{default: 0};
    logic   clr_m      [`PID_N_CHAN] = '{default: 1'b0};

    // Model history per channel
    longint e1_m [`PID_N_CHAN] = '{default: 0};
    longint e2_m [`PID_N_CHAN] = '{default: 0};
    longint y_m  [`PID_N_CHAN] = '{default: 0};

    // Pending outputs, channel in the top bits
    logic [`PID_W_CHAN+`PID_W_DATA_OUT-1:0] exp_q [$];
    logic [`PID_W_CHAN+`PID_W_DATA_OUT-1:0] exp_entry;

    int check_count = 0;
    int error_count = 0;

    //----------------------------------------------------------------------
    // Reference model
    //----------------------------------------------------------------------
    // Incremental PID step, clamped to the signed output range
    function automatic longint pid_ref(input longint e, input longint e1, input longint e2,
                                       input longint y_prev, input longint p,
                                       input longint i, input longint d);
        longint y;
        y = y_prev + (p + i + d) * e + (-p - 2 * d) * e1 + d * e2;
        if (y > OUT_MAX) begin
            y = OUT_MAX;
        end else if (y < OUT_MIN) begin
            y = OUT_MIN;
        end
        return y;
    endfunction

    // Mirror of one register write
    task automatic model_write(input logic [`PID_W_WR_ADDR-1:0] addr,
                               input logic [`PID_W_CHAN-1:0] chan,
                               input logic [`PID_W_WR_DATA-1:0] data);
        case (addr)
            pid_pkg::REG_CLEAR: begin
                clr_m[chan] = data[0];
                if (data[0]) begin
                    e1_m[chan] = 0;
                    e2_m[chan] = 0;
                    y_m[chan]  = 0;
                    // In-flight samples of this channel never come out
                    for (int n = exp_q.size() - 1; n >= 0; n--) begin
                        if (exp_q[n][`PID_W_DATA_OUT +: `PID_W_CHAN] == chan) begin
                            exp_q.delete(n);
                        end
                    end
                end
            end
            pid_pkg::REG_SETPOINT: setpoint_m[chan] = $signed(data[`PID_W_DATA_IN-1:0]);
            pid_pkg::REG_P_COEF:   p_m[chan] = $signed(data[`PID_W_COEF-1:0]);
            pid_pkg::REG_I_COEF:   i_m[chan] = $signed(data[`PID_W_COEF-1:0]);
            pid_pkg::REG_D_COEF:   d_m[chan] = $signed(data[`PID_W_COEF-1:0]);
            default: ;
        endcase
    endtask

    // One sample into the model, queues its expected output
    task automatic model_sample(input logic [`PID_W_CHAN-1:0] chan,
                                input logic [`PID_W_DATA_IN-1:0] data);
        longint e;
        longint y;
        // Cleared channel drops the sample and keeps zero history
        if (!clr_m[chan]) begin
            e = setpoint_m[chan] - longint'($signed(data));
            y = pid_ref(e, e1_m[chan], e2_m[chan], y_m[chan], p_m[chan], i_m[chan], d_m[chan]);
            e2_m[chan] = e1_m[chan];
            e1_m[chan] = e;
            y_m[chan]  = y;
            exp_q.push_back({chan, y[`PID_W_DATA_OUT-1:0]});
        end
    endtask

    // Nothing may be left pending once a test has drained
    task automatic check_drained();
        if (exp_q.size() != 0) begin
            error_count++;
            $display("[%0t ns] %0d expected outputs never appeared", $time, exp_q.size());
            exp_q.delete();
        end
    endtask

    //----------------------------------------------------------------------
    // Output compare
    //----------------------------------------------------------------------
    // Outputs move on the rising edge, so the falling edge sees them settled
    always @(negedge sys_clk_in) begin
        if (dv_out) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("[%0t ns] Output on channel %0d arrived with no sample pending",
                         $time, chan_out);
            end else begin
                exp_entry = exp_q.pop_front();
                check_count++;
                if (chan_out !== exp_entry[`PID_W_DATA_OUT +: `PID_W_CHAN]) begin
                    error_count++;
                    $display("FAIL %0t ns chan_out expected %0d actual %0d", $time,
                             exp_entry[`PID_W_DATA_OUT +: `PID_W_CHAN], chan_out);
                end
                if (data_out !== exp_entry[`PID_W_DATA_OUT-1:0]) begin
                    error_count++;
                    $display("FAIL %0t ns data_out expected %0d actual %0d", $time,
                             $signed(exp_entry[`PID_W_DATA_OUT-1:0]), $signed(data_out));
                end
            end
        end
    end

endmodule

`default_nettype wire

/* test/pid_tb.sv */
`include "pid_defines.svh"
`default_nettype none

module pid_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // Cycle estimate per test, reset first
    localparam int RESET_CYCLES   = 16;
    localparam int SEQ_CYCLES     = RESET_CYCLES + 30 + 150 + 300 + 160 + 150 + 100;
    localparam int TIMEOUT_CYCLES = SEQ_CYCLES * 3 / 2;

    logic                        sys_clk_in = 1'b0;
    logic                        arst_n;
    logic                        wr_en;
    logic [`PID_W_WR_ADDR-1:0]   wr_addr;
    logic [`PID_W_CHAN-1:0]      wr_chan;
    logic [`PID_W_WR_DATA-1:0]   wr_data;
    logic                        dv_in;
    logic [`PID_W_CHAN-1:0]      chan_in;
    logic [`PID_W_DATA_IN-1:0]   data_in;
    logic                        dv_out;
    logic [`PID_W_CHAN-1:0]      chan_out;
    logic [`PID_W_DATA_OUT-1:0]  data_out;

    logic [31:0] rng_state     = 32'h2df31f35;
    int          cycle_count   = 0;
    int          test_count    = 0;
    int          errors_before = 0;

    // 40 ns period
    always #20 sys_clk_in = ~sys_clk_in;

    pid_top u_pid_top (
        .sys_clk_in (sys_clk_in),
        .arst_n     (arst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_chan    (wr_chan),
        .wr_data    (wr_data),
        .dv_in      (dv_in),
        .chan_in    (chan_in),
        .data_in    (data_in),
        .dv_out     (dv_out),
        .chan_out   (chan_out),
        .data_out   (data_out)
    );

    pid_monitor u_monitor (
        .sys_clk_in (sys_clk_in),
        .dv_out     (dv_out),
        .chan_out   (chan_out),
        .data_out   (data_out)
    );

    bind pid_top pid_chk u_chk (
        .sys_clk_in (sys_clk_in),
        .arst_n     (arst_n),
        .dv_in      (dv_in),
        .chan_in    (chan_in),
        .dv_out     (dv_out),
        .chan_out   (chan_out),
        .data_out   (data_out)
    );

    //----------------------------------------------------------------------
    // Helpers
    //----------------------------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Signed random value of the given width, from the upper LCG bits
    function automatic int rand_signed(input int bits);
        rng_state = lcg_next(rng_state);
        return $signed(rng_state) >>> (32 - bits);
    endfunction

    function automatic int total_errors();
        return u_monitor.error_count + u_pid_top.u_chk.assert_fails;
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge sys_clk_in);
            wr_en = 1'b0;
            dv_in = 1'b0;
        end
    endtask

    task automatic write_reg(input logic [`PID_W_WR_ADDR-1:0] addr,
                             input logic [`PID_W_CHAN-1:0] chan,
                             input logic [`PID_W_WR_DATA-1:0] data);
        @(negedge sys_clk_in);
        dv_in   = 1'b0;
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_chan = chan;
        wr_data = data;
        u_monitor.model_write(addr, chan, data);
    endtask

    task automatic send_sample(input logic [`PID_W_CHAN-1:0] chan,
                               input logic [`PID_W_DATA_IN-1:0] data);
        @(negedge sys_clk_in);
        wr_en   = 1'b0;
        dv_in   = 1'b1;
        chan_in = chan;
        data_in = data;
        u_monitor.model_sample(chan, data);
    endtask

    // Drain, then one summary line for the test
    task automatic end_test(input string name);
        int errs;
        idle(10);
        u_monitor.check_drained();
        test_count++;
        errs          = total_errors() - errors_before;
        errors_before = total_errors();
        $display("[%0t ns] test %0d %s: %s", $time, test_count, name,
                 (errs == 0) ? "ok" : "errors");
    endtask

    // Hang guard
    always @(posedge sys_clk_in) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    //----------------------------------------------------------------------
    // Test sequence
    //----------------------------------------------------------------------
    initial begin
        arst_n  = 1'b0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_chan = '0;
        wr_data = '0;
        dv_in   = 1'b0;
        chan_in = '0;
        data_in = '0;
        repeat (RESET_CYCLES) @(negedge sys_clk_in);
        arst_n = 1'b1;

        // Zero gains give zero output on every channel
        for (int c = 0; c < `PID_N_CHAN; c++) begin
            send_sample(`PID_W_CHAN'(c), 16'(rand_signed(16)));
        end
        end_test("reset state");

        // Step on channel 2, integral builds up
        write_reg(pid_pkg::REG_SETPOINT, 3'd2, 32'd1000);
        write_reg(pid_pkg::REG_P_COEF, 3'd2, 32'd4);
        write_reg(pid_pkg::REG_I_COEF, 3'd2, 32'd2);
        write_reg(pid_pkg::REG_D_COEF, 3'd2, 32'd1);
        for (int n = 0; n < 16; n++) begin
            send_sample(3'd2, 16'd900);
            idle(7);
        end
        end_test("step response");

        // Random config on all channels, junk in the upper data bits
        for (int c = 0; c < `PID_N_CHAN; c++) begin
            write_reg(pid_pkg::REG_SETPOINT, `PID_W_CHAN'(c), 32'(rand_signed(12)));
            write_reg(pid_pkg::REG_P_COEF, `PID_W_CHAN'(c), {16'ha5c3, 16'(rand_signed(9))});
            write_reg(pid_pkg::REG_I_COEF, `PID_W_CHAN'(c), {16'ha5c3, 16'(rand_signed(9))});
            write_reg(pid_pkg::REG_D_COEF, `PID_W_CHAN'(c), {16'ha5c3, 16'(rand_signed(9))});
        end
        // Channel rotates every cycle, eight apart per channel
        for (int n = 0; n < 240; n++) begin
            send_sample(`PID_W_CHAN'(n), 16'(rand_signed(12)));
        end
        end_test("interleaved channels");

        // Full-scale error of both signs on channel 5
        write_reg(pid_pkg::REG_SETPOINT, 3'd5, 32'h7fff);
        write_reg(pid_pkg::REG_P_COEF, 3'd5, 32'd30000);
        write_reg(pid_pkg::REG_I_COEF, 3'd5, 32'd30000);
        write_reg(pid_pkg::REG_D_COEF, 3'd5, 32'd100);
        for (int n = 0; n < 6; n++) begin
            send_sample(3'd5, 16'h8000);
            idle(7);
        end
        write_reg(pid_pkg::REG_SETPOINT, 3'd5, 32'h8000);
        idle(7);
        for (int n = 0; n < 8; n++) begin
            send_sample(3'd5, 16'h7fff);
            idle(7);
        end
        end_test("saturation");

        // Channel 1 cleared with a sample in flight
        send_sample(3'd1, 16'(rand_signed(12)));
        send_sample(3'd2, 16'(rand_signed(12)));
        send_sample(3'd3, 16'(rand_signed(12)));
        write_reg(pid_pkg::REG_CLEAR, 3'd1, 32'd1);
        idle(5);
        for (int n = 0; n < 4; n++) begin
            send_sample(3'd1, 16'(rand_signed(12)));
            send_sample(3'd2, 16'(rand_signed(12)));
            send_sample(3'd3, 16'(rand_signed(12)));
            idle(5);
        end
        // Released channel restarts from zero history
        write_reg(pid_pkg::REG_CLEAR, 3'd1, 32'd0);
        for (int n = 0; n < 4; n++) begin
            send_sample(3'd1, 16'(rand_signed(12)));
            send_sample(3'd2, 16'(rand_signed(12)));
            idle(6);
        end
        end_test("channel clear");

        // Gains rewritten between samples of channel 6
        write_reg(pid_pkg::REG_SETPOINT, 3'd6, 32'd500);
        write_reg(pid_pkg::REG_P_COEF, 3'd6, 32'd20);
        write_reg(pid_pkg::REG_I_COEF, 3'd6, 32'd3);
        write_reg(pid_pkg::REG_D_COEF, 3'd6, 32'd5);
        for (int n = 0; n < 3; n++) begin
            send_sample(3'd6, 16'(rand_signed(10)));
            idle(7);
        end
        send_sample(3'd6, 16'(rand_signed(10)));
        // In-flight sample keeps the gains it was fetched with
        write_reg(pid_pkg::REG_P_COEF, 3'd6, 32'(-40));
        write_reg(pid_pkg::REG_D_COEF, 3'd6, 32'd12);
        // Unmapped address, no effect
        write_reg(4'd9, 3'd6, 32'hffff_ffff);
        idle(4);
        for (int n = 0; n < 3; n++) begin
            send_sample(3'd6, 16'(rand_signed(10)));
            idle(7);
        end
        end_test("coefficient rewrite");

        $display("Tests %0d, checks %0d, monitor errors %0d, assertion failures %0d",
                 test_count, u_monitor.check_count, u_monitor.error_count,
                 u_pid_top.u_chk.assert_fails);
        if (total_errors() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+source
source/pid_pkg.sv
source/pid_cfg_if.sv
source/pid_cfg_regs.sv
source/pid_pipeline.sv
source/pid_top.sv
test/pid_chk.sv
test/pid_monitor.sv
test/pid_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the PID controller testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f filelist.f --top-module pid_tb -o pid_sim

# Assertion errors must not end the run before the summary is printed
./obj_dir/pid_sim +verilator+error+limit+1000 2>&1 | tee "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

echo "Simulation finished without failures, see $LOG"
